/* sources.f */
source/track_match_pkg.sv
source/paged_memory.sv
source/match_calculator.sv
source/track_match_top.sv
test/track_match_properties.sv
test/track_match_tb.sv

/* Bender.yml */
package:
  name: track_match

sources:
  - source/track_match_pkg.sv
  - source/paged_memory.sv
  - source/match_calculator.sv
  - source/track_match_top.sv
  - target: test
    files:
      - test/track_match_properties.sv
      - test/track_match_tb.sv

/* test/track_match_tb.sv */
`timescale 1ns/1ps

module track_match_tb
  import track_match_pkg::*;
();

  localparam int DONE_TIMEOUT = 10000;
  localparam int WAIT_TIMEOUT = 30000;

  logic         clk;
  logic         reset;
  logic         en_proc;
  bx_t          bx_in;
  proj_write_t  proj_write;
  count_write_t proj_count_write;
  stub_write_t  stub_write;
  count_write_t stub_count_write;
  logic         fm_rpage;
  entry_t       fm_rentry;
  full_match_t  fm_rdata;
  count_t [1:0] fm_count;
  logic         done;
  bx_t          bx_out;

  // Testbench copy of both pages and the expected full matches
  proj_t       proj_mem [2][PAGE_ENTRIES];
  stub_t       stub_mem [2][PAGE_ENTRIES];
  int          proj_n [2];
  int          stub_n [2];
  full_match_t exp_fm [2][PAGE_ENTRIES];
  int          exp_n [2];

  logic [15:0] lfsr;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          done_pulses;
  int          pulses_before;
  int          errs_before;
  int          t;
  logic        check_req;
  logic        check_wait_done;
  logic        exp_page;
  bx_t         exp_bx;
  string       test_name;

  track_match_top dut_i (
    .clk              (clk),
    .reset            (reset),
    .en_proc          (en_proc),
    .bx_in            (bx_in),
    .proj_write       (proj_write),
    .proj_count_write (proj_count_write),
    .stub_write       (stub_write),
    .stub_count_write (stub_count_write),
    .fm_rpage         (fm_rpage),
    .fm_rentry        (fm_rentry),
    .fm_rdata         (fm_rdata),
    .fm_count         (fm_count),
    .done             (done),
    .bx_out           (bx_out)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(negedge clk) begin
    if (done) begin
      done_pulses++;
    end
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic int rand_bits(input int n);
    int v;
    int i;
    v = 0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  function automatic int abs_diff(input int a, input int b);
    return (a > b) ? a - b : b - a;
  endfunction

  function automatic int clamp(input int v, input int hi);
    if (v < 0) begin
      return 0;
    end
    return (v > hi) ? hi : v;
  endfunction

  // Expected matches of a page, straight from the match rule
  function automatic void build_expected(input logic pg);
    int p;
    int s;
    int d;
    int best_d;
    int best_s;
    exp_n[pg] = 0;
    for (p = 0; p < proj_n[pg]; p++) begin
      best_s = -1;
      best_d = 0;
      for (s = 0; s < stub_n[pg]; s++) begin
        d = abs_diff(proj_mem[pg][p].phi, stub_mem[pg][s].phi);
        if (d <= PHI_CUT && abs_diff(proj_mem[pg][p].z, stub_mem[pg][s].z) <= Z_CUT) begin
          if (best_s < 0 || d < best_d) begin
            best_s = s;
            best_d = d;
          end
        end
      end
      if (best_s >= 0) begin
        exp_fm[pg][exp_n[pg]] = '{tcid: proj_mem[pg][p].tcid,
                                  stub_entry: entry_t'(best_s), dphi: phi_t'(best_d)};
        exp_n[pg]++;
      end
    end
  endfunction

  // Half of the stubs land near a projection, the rest anywhere
  function automatic void fill_random(input logic pg, input int np, input int ns);
    int i;
    int k;
    proj_n[pg] = np;
    stub_n[pg] = ns;
    for (i = 0; i < np; i++) begin
      proj_mem[pg][i].tcid = tc_t'(rand_bits(TC_BITS));
      proj_mem[pg][i].phi  = phi_t'(rand_bits(PHI_BITS));
      proj_mem[pg][i].z    = z_t'(rand_bits(Z_BITS));
    end
    for (i = 0; i < ns; i++) begin
      if (np > 0 && rand_bits(1) == 1) begin
        k = rand_bits(ENTRY_BITS) % np;
        stub_mem[pg][i].phi = phi_t'(clamp(proj_mem[pg][k].phi + rand_bits(8) - 128, 4095));
        stub_mem[pg][i].z   = z_t'(clamp(proj_mem[pg][k].z + rand_bits(6) - 32, 1023));
      end else begin
        stub_mem[pg][i].phi = phi_t'(rand_bits(PHI_BITS));
        stub_mem[pg][i].z   = z_t'(rand_bits(Z_BITS));
      end
    end
  endfunction

  // Projections in the lowest quarter of phi, stubs in the third quarter
  function automatic void make_far(input logic pg);
    int i;
    for (i = 0; i < proj_n[pg]; i++) begin
      proj_mem[pg][i].phi = proj_mem[pg][i].phi & 12'h3FF;
    end
    for (i = 0; i < stub_n[pg]; i++) begin
      stub_mem[pg][i].phi = proj_mem[pg][i % proj_n[pg]].phi | 12'h800;
      stub_mem[pg][i].z   = proj_mem[pg][i % proj_n[pg]].z;
    end
  endfunction

  function automatic void make_tie(input logic pg);
    proj_n[pg] = 1;
    stub_n[pg] = 4;
    proj_mem[pg][0] = '{tcid: 7'd5, phi: 12'd1000, z: 10'd500};
    stub_mem[pg][0] = '{phi: 12'd3000, z: 10'd500};
    stub_mem[pg][1] = '{phi: 12'd1010, z: 10'd500};
    stub_mem[pg][2] = '{phi: 12'd990, z: 10'd510};
    stub_mem[pg][3] = '{phi: 12'd1000, z: 10'd600};
  endfunction

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic end_test(input string name, input int errs);
    tests_run++;
    if (errs == 0) begin
      $display("test %-24s ok", name);
    end else begin
      tests_failed++;
      $display("test %-24s failed with %0d errors", name, errs);
    end
  endtask

  task automatic load_page(input logic pg);
    int i;
    for (i = 0; i < PAGE_ENTRIES; i++) begin
      @(negedge clk);
      proj_write = '{en: (i < proj_n[pg]), page: pg, entry: entry_t'(i),
                     data: proj_mem[pg][i]};
      stub_write = '{en: (i < stub_n[pg]), page: pg, entry: entry_t'(i),
                     data: stub_mem[pg][i]};
    end
    @(negedge clk);
    proj_write.en    = 1'b0;
    stub_write.en    = 1'b0;
    proj_count_write = '{en: pg ? 2'b10 : 2'b01, value: count_t'(proj_n[pg])};
    stub_count_write = '{en: pg ? 2'b10 : 2'b01, value: count_t'(stub_n[pg])};
    @(negedge clk);
    proj_count_write.en = 2'b00;
    stub_count_write.en = 2'b00;
  endtask

  task automatic compare_results();
    int n;
    int i;
    int errs0;
    errs0 = errors;
    if (check_wait_done) begin
      n = 0;
      while (!done && n < DONE_TIMEOUT) begin
        @(negedge clk);
        n++;
      end
      if (!done) begin
        $display("Timeout: done never came for test %s", test_name);
        errors++;
      end else if (bx_out !== exp_bx) begin
        report_fail($sformatf("%s: bx_out %0d, expected %0d", test_name, bx_out, exp_bx));
      end
      // Count register loads at the end of the done cycle
      @(negedge clk);
    end
    if (fm_count[exp_page] !== count_t'(exp_n[exp_page])) begin
      report_fail($sformatf("%s: fm count %0d, expected %0d", test_name,
                            fm_count[exp_page], exp_n[exp_page]));
    end
    for (i = 0; i < exp_n[exp_page]; i++) begin
      fm_rpage  = exp_page;
      fm_rentry = entry_t'(i);
      @(negedge clk);
      if (fm_rdata !== exp_fm[exp_page][i]) begin
        report_fail($sformatf("%s: entry %0d is %h, expected %h", test_name, i,
                              fm_rdata, exp_fm[exp_page][i]));
      end
    end
    end_test(test_name, errors - errs0);
  endtask

  // Compare process
  always @(negedge clk) begin
    if (check_req) begin
      compare_results();
      check_req = 1'b0;
    end
  end

  task automatic wait_check();
    int n;
    n = 0;
    while (check_req && n < WAIT_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (check_req) begin
      $display("Timeout: the compare for test %s never finished", test_name);
      errors++;
    end
  endtask

  task automatic run_event(input string name, input bx_t bx, input int restart_after);
    test_name       = name;
    exp_page        = bx[0];
    exp_bx          = bx;
    check_wait_done = 1'b1;
    build_expected(bx[0]);
    @(negedge clk);
    check_req = 1'b1;
    en_proc   = 1'b1;
    bx_in     = bx;
    @(negedge clk);
    en_proc = 1'b0;
    if (restart_after > 0) begin
      repeat (restart_after) @(negedge clk);
      en_proc = 1'b1;
      bx_in   = bx + 3'd1;
      @(negedge clk);
      en_proc = 1'b0;
    end
    wait_check();
  endtask

  task automatic recheck_page(input string name, input logic pg);
    test_name       = name;
    exp_page        = pg;
    check_wait_done = 1'b0;
    @(negedge clk);
    check_req = 1'b1;
    wait_check();
  endtask

  initial begin
    lfsr             = 16'd6;
    errors           = 0;
    tests_run        = 0;
    tests_failed     = 0;
    done_pulses      = 0;
    en_proc          = 1'b0;
    bx_in            = '0;
    proj_write       = '0;
    proj_count_write = '0;
    stub_write       = '0;
    stub_count_write = '0;
    fm_rpage         = 1'b0;
    fm_rentry        = '0;
    check_req        = 1'b0;
    check_wait_done  = 1'b0;
    exp_page         = 1'b0;
    exp_bx           = '0;
    test_name        = "";
    reset            = 1'b1;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    errs_before = errors;
    if (done !== 1'b0) begin
      report_fail("done is not low after reset");
    end
    if (fm_count[0] !== '0 || fm_count[1] !== '0) begin
      report_fail("fm counts are not 0 after reset");
    end
    end_test("after reset", errors - errs_before);

    fill_random(1'b0, 24, 40);
    load_page(1'b0);
    run_event("random bx 2", 3'd2, 0);

    fill_random(1'b1, 30, 48);
    load_page(1'b1);
    run_event("random bx 3", 3'd3, 0);
    recheck_page("page 0 kept", 1'b0);

    fill_random(1'b1, 0, 10);
    load_page(1'b1);
    run_event("no projections", 3'd1, 0);

    fill_random(1'b0, 16, 32);
    make_far(1'b0);
    load_page(1'b0);
    run_event("all stubs outside", 3'd0, 0);

    make_tie(1'b0);
    load_page(1'b0);
    run_event("tie picks lower entry", 3'd6, 0);

    fill_random(1'b0, 20, 40);
    load_page(1'b0);
    pulses_before = done_pulses;
    run_event("start while busy", 3'd4, 10);
    errs_before = errors;
    // Window for a stray second done
    for (t = 0; t < 300; t++) begin
      @(negedge clk);
    end
    if (done_pulses != pulses_before + 1) begin
      report_fail($sformatf("%0d done pulses, expected 1", done_pulses - pulses_before));
    end
    end_test("single done pulse", errors - errs_before);

    errors = errors + int'(dut_i.calc.props_i.assert_failures);
    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d", tests_run,
             tests_failed, errors, dut_i.calc.props_i.assert_failures);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* test/track_match_properties.sv */
`timescale 1ns/1ps

module track_match_properties
  import track_match_pkg::*;
(
  input logic      clk,
  input logic      reset,
  input logic      start,
  input mc_state_t state,
  input logic      done,
  input logic      fm_write_en,
  input bx_t       bx_out
);

  int unsigned assert_failures = 0;

  done_one_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else begin
      assert_failures++;
      $error("done lasted more than one cycle");
    end

  // Sync reset, so done is low the cycle after any reset edge
  done_low_in_reset: assert property (@(posedge clk) reset |=> !done)
    else begin
      assert_failures++;
      $error("done high during reset");
    end

  write_only_in_store: assert property (@(posedge clk) disable iff (reset)
    fm_write_en |-> state == STORE)
    else begin
      assert_failures++;
      $error("full-match write outside STORE");
    end

  // A start while busy must not restart the event
  busy_start_ignored: assert property (@(posedge clk) disable iff (reset)
    (start && state != IDLE) |=> $stable(bx_out))
    else begin
      assert_failures++;
      $error("start while busy changed the latched bx");
    end

endmodule

bind match_calculator track_match_properties props_i (
  .clk         (clk),
  .reset       (reset),
  .start       (start),
  .state       (state),
  .done        (done),
  .fm_write_en (fm_write.en),
  .bx_out      (bx_out)
);

/* source/track_match_top.sv */
`timescale 1ns/1ps

module track_match_top
  import track_match_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         en_proc,
  input  bx_t          bx_in,
  // Projection and stub fill
  input  proj_write_t  proj_write,
  input  count_write_t proj_count_write,
  input  stub_write_t  stub_write,
  input  count_write_t stub_count_write,
  // Full-match readback
  input  logic         fm_rpage,
  input  entry_t       fm_rentry,
  output full_match_t  fm_rdata,
  output count_t [1:0] fm_count,
  output logic         done,
  output bx_t          bx_out
);

  logic         page;
  entry_t       proj_rentry;
  entry_t       stub_rentry;
  proj_t        proj_rdata;
  stub_t        stub_rdata;
  count_t [1:0] proj_count;
  count_t [1:0] stub_count;
  fm_write_t    fm_write;
  count_write_t fm_count_write;

  paged_memory #(
    .WIDTH($bits(proj_t))
  ) proj_store (
    .clk       (clk),
    .reset     (reset),
    .we        (proj_write.en),
    .wpage     (proj_write.page),
    .wentry    (proj_write.entry),
    .wdata     (proj_write.data),
    .count_we  (proj_count_write.en),
    .count_din (proj_count_write.value),
    .rpage     (page),
    .rentry    (proj_rentry),
    .rdata     (proj_rdata),
    .count     (proj_count)
  );

  paged_memory #(
    .WIDTH($bits(stub_t))
  ) stub_store (
    .clk       (clk),
    .reset     (reset),
    .we        (stub_write.en),
    .wpage     (stub_write.page),
    .wentry    (stub_write.entry),
    .wdata     (stub_write.data),
    .count_we  (stub_count_write.en),
    .count_din (stub_count_write.value),
    .rpage     (page),
    .rentry    (stub_rentry),
    .rdata     (stub_rdata),
    .count     (stub_count)
  );

  match_calculator calc (
    .clk         (clk),
    .reset       (reset),
    .start       (en_proc),
    .bx_in       (bx_in),
    .proj_count  (proj_count),
    .stub_count  (stub_count),
    .proj_rentry (proj_rentry),
    .proj_rdata  (proj_rdata),
    .stub_rentry (stub_rentry),
    .stub_rdata  (stub_rdata),
    .page        (page),
    .fm_write    (fm_write),
    .fm_count    (fm_count_write),
    .done        (done),
    .bx_out      (bx_out)
  );

  // Read side belongs to the outside
  paged_memory #(
    .WIDTH($bits(full_match_t))
  ) fm_store (
    .clk       (clk),
    .reset     (reset),
    .we        (fm_write.en),
    .wpage     (fm_write.page),
    .wentry    (fm_write.entry),
    .wdata     (fm_write.data),
    .count_we  (fm_count_write.en),
    .count_din (fm_count_write.value),
    .rpage     (fm_rpage),
    .rentry    (fm_rentry),
    .rdata     (fm_rdata),
    .count     (fm_count)
  );

endmodule

/* source/match_calculator.sv */
`timescale 1ns/1ps

module match_calculator
  import track_match_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         start,
  input  bx_t          bx_in,
  input  count_t [1:0] proj_count,
  input  count_t [1:0] stub_count,
  // Projection store read
  output entry_t       proj_rentry,
  input  proj_t        proj_rdata,
  // Stub store read
  output entry_t       stub_rentry,
  input  stub_t        stub_rdata,
  output logic         page,
  // Full-match store write
  output fm_write_t    fm_write,
  output count_write_t fm_count,
  output logic         done,
  output bx_t          bx_out
);

  mc_state_t state;
  bx_t       bx_q;

  count_t proj_idx;
  count_t stub_addr;
  count_t fm_idx;
  count_t proj_total;
  count_t stub_total;

  // Entry whose data sits on stub_rdata this cycle
  entry_t stub_cur;
  logic   stub_valid;

  logic   best_found;
  entry_t best_entry;
  phi_t   best_dphi;

  phi_t dphi;
  z_t   dz;
  logic in_cut;
  logic better;

  assign page       = bx_q[0];
  assign proj_total = proj_count[page];
  assign stub_total = stub_count[page];

  // Projection address stays put through SCAN and STORE
  assign proj_rentry = proj_idx[ENTRY_BITS-1:0];
  assign stub_rentry = stub_addr[ENTRY_BITS-1:0];

  always_comb begin
    if (proj_rdata.phi > stub_rdata.phi) begin
      dphi = proj_rdata.phi - stub_rdata.phi;
    end else begin
      dphi = stub_rdata.phi - proj_rdata.phi;
    end
    if (proj_rdata.z > stub_rdata.z) begin
      dz = proj_rdata.z - stub_rdata.z;
    end else begin
      dz = stub_rdata.z - proj_rdata.z;
    end
  end

  assign in_cut = stub_valid && (dphi <= phi_t'(PHI_CUT)) && (dz <= z_t'(Z_CUT));
  // Strict compare, so the earlier entry survives a tie
  assign better = !best_found || (dphi < best_dphi);

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      bx_q       <= '0;
      proj_idx   <= '0;
      stub_addr  <= '0;
      fm_idx     <= '0;
      stub_cur   <= '0;
      stub_valid <= 1'b0;
      best_found <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            bx_q      <= bx_in;
            proj_idx  <= '0;
            stub_addr <= '0;
            fm_idx    <= '0;
            state     <= READ_PROJ;
          end
        end
        READ_PROJ: begin
          if (proj_idx >= proj_total) begin
            state <= FINISH;
          end else begin
            stub_cur   <= stub_addr[ENTRY_BITS-1:0];
            stub_valid <= stub_addr < stub_total;
            stub_addr  <= stub_addr + 1'b1;
            best_found <= 1'b0;
            state      <= SCAN;
          end
        end
        SCAN: begin
          if (!stub_valid) begin
            state <= STORE;
          end else begin
            if (in_cut && better) begin
              best_found <= 1'b1;
            end
            stub_cur   <= stub_addr[ENTRY_BITS-1:0];
            stub_valid <= stub_addr < stub_total;
            stub_addr  <= stub_addr + 1'b1;
          end
        end
        STORE: begin
          fm_idx    <= fm_idx + count_t'(best_found);
          proj_idx  <= proj_idx + 1'b1;
          stub_addr <= '0;
          state     <= READ_PROJ;
        end
        FINISH: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == SCAN && in_cut && better) begin
      best_entry <= stub_cur;
      best_dphi  <= dphi;
    end
  end

  always_comb begin
    fm_write.en              = (state == STORE) && best_found;
    fm_write.page            = page;
    fm_write.entry           = fm_idx[ENTRY_BITS-1:0];
    fm_write.data.tcid       = proj_rdata.tcid;
    fm_write.data.stub_entry = best_entry;
    fm_write.data.dphi       = best_dphi;
  end

  always_comb begin
    fm_count.en    = 2'b00;
    fm_count.value = fm_idx;
    if (state == FINISH) begin
      fm_count.en = page ? 2'b10 : 2'b01;
    end
  end

  assign done   = (state == FINISH);
  assign bx_out = bx_q;

endmodule

/* source/paged_memory.sv */
`timescale 1ns/1ps

module paged_memory
  import track_match_pkg::*;
#(
  parameter int WIDTH = 29
) (
  input  logic             clk,
  input  logic             reset,
  // Write port
  input  logic             we,
  input  logic             wpage,
  input  entry_t           wentry,
  input  logic [WIDTH-1:0] wdata,
  // Entry counts, one per page
  input  logic [1:0]       count_we,
  input  count_t           count_din,
  // Read port
  input  logic             rpage,
  input  entry_t           rentry,
  output logic [WIDTH-1:0] rdata,
  output count_t [1:0]     count
);

  // Page bit on top, entry below
  logic [WIDTH-1:0] mem [2*PAGE_ENTRIES];

  logic [ENTRY_BITS:0] waddr;
  logic [ENTRY_BITS:0] raddr;

  assign waddr = {wpage, wentry};
  assign raddr = {rpage, rentry};

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Data appears the cycle after the address
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (count_we[p]) begin
          count[p] <= count_din;
        end
      end
    end
  end

endmodule

/* source/track_match_pkg.sv */
package track_match_pkg;

  localparam int PAGE_ENTRIES = 64;
  localparam int ENTRY_BITS   = 6;
  localparam int COUNT_BITS   = 7;
  localparam int PHI_BITS     = 12;
  localparam int Z_BITS       = 10;
  localparam int TC_BITS      = 7;
  localparam int BX_BITS      = 3;

  // Match window, in raw coordinate units
  localparam int PHI_CUT = 64;
  localparam int Z_CUT   = 32;

  typedef logic [BX_BITS-1:0]    bx_t;
  typedef logic [ENTRY_BITS-1:0] entry_t;
  typedef logic [COUNT_BITS-1:0] count_t;
  typedef logic [PHI_BITS-1:0]   phi_t;
  typedef logic [Z_BITS-1:0]     z_t;
  typedef logic [TC_BITS-1:0]    tc_t;

  typedef struct packed {
    tc_t  tcid;
    phi_t phi;
    z_t   z;
  } proj_t;

  typedef struct packed {
    phi_t phi;
    z_t   z;
  } stub_t;

  // Residual is the unsigned absolute phi difference
  typedef struct packed {
    tc_t    tcid;
    entry_t stub_entry;
    phi_t   dphi;
  } full_match_t;

  typedef struct packed {
    logic   en;
    logic   page;
    entry_t entry;
    proj_t  data;
  } proj_write_t;

  typedef struct packed {
    logic   en;
    logic   page;
    entry_t entry;
    stub_t  data;
  } stub_write_t;

  typedef struct packed {
    logic        en;
    logic        page;
    entry_t      entry;
    full_match_t data;
  } fm_write_t;

  // One enable bit per page
  typedef struct packed {
    logic [1:0] en;
    count_t     value;
  } count_write_t;

  typedef enum logic [2:0] {
    IDLE,
    READ_PROJ,
    SCAN,
    STORE,
    FINISH
  } mc_state_t;

endpackage
